// ==== files.f ====
verilog/eeprom_bus_pkg.sv
verilog/eeprom_sys_pkg.sv
verilog/eeprom_cmd_dispatch.sv
verilog/eeprom_bus_master.sv
verilog/eeprom_result_collect.sv
verilog/eeprom_multi_ctrl.sv
test/eeprom_model.sv
test/tb_eeprom_multi_ctrl.sv

// ==== Bender.yml ====
package:
  name: eeprom_multi_ctrl

sources:
  - verilog/eeprom_bus_pkg.sv
  - verilog/eeprom_sys_pkg.sv
  - verilog/eeprom_cmd_dispatch.sv
  - verilog/eeprom_bus_master.sv
  - verilog/eeprom_result_collect.sv
  - verilog/eeprom_multi_ctrl.sv
  - target: test
    files:
      - test/eeprom_model.sv
      - test/tb_eeprom_multi_ctrl.sv

// ==== test/tb_eeprom_multi_ctrl.sv ====
`default_nettype none

module tb_eeprom_multi_ctrl;

    logic                                CLK;
    logic                                RESET;
    logic                                req_wr;
    logic                                req_rd;
    logic [eeprom_sys_pkg::CHAN_W-1:0]   req_chan;
    logic [eeprom_bus_pkg::ADDR_W-1:0]   req_addr;
    logic [eeprom_bus_pkg::DATA_W-1:0]   req_wdata;
    wire                                 req_reject;
    wire                                 rsp_valid;
    wire                                 rsp_nack;
    wire  [eeprom_sys_pkg::CHAN_W-1:0]   rsp_chan;
    wire  [eeprom_bus_pkg::DATA_W-1:0]   rsp_rdata;
    wire  [eeprom_sys_pkg::NUM_CHAN-1:0] busy;
    wire  [eeprom_sys_pkg::NUM_CHAN-1:0] scl;
    wire  [eeprom_sys_pkg::NUM_CHAN-1:0] sda;
    logic                                chan3_present;

    int          cycles;
    int          rsp_seen;
    int          reject_seen;
    int unsigned seed;
    logic [eeprom_bus_pkg::ADDR_W-1:0] par_addr [0:2];
    logic [eeprom_bus_pkg::DATA_W-1:0] par_data [0:2];

    eeprom_multi_ctrl eeprom_multi_ctrl_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_wr     (req_wr),
        .req_rd     (req_rd),
        .req_chan   (req_chan),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_reject (req_reject),
        .rsp_valid  (rsp_valid),
        .rsp_nack   (rsp_nack),
        .rsp_chan   (rsp_chan),
        .rsp_rdata  (rsp_rdata),
        .busy       (busy),
        .scl        (scl),
        .sda        (sda)
    );

    genvar g;
    generate
        for (g = 0; g < eeprom_sys_pkg::NUM_CHAN; g++)
        begin : gen_bus
            pullup (sda[g]);
            eeprom_model eeprom_model_i (
                .scl     (scl[g]),
                .sda     (sda[g]),
                .present (g == eeprom_sys_pkg::NUM_CHAN - 1 ? chan3_present : 1'b1)
            );
        end
    endgenerate

    always #10 CLK = ~CLK;

    // ~20 transactions of at most ~200 cycles, plus a wide margin
    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycles >= 40000)
        begin
            $display("timeout: the run did not finish within 40000 cycles");
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(negedge CLK)
    begin
        if (rsp_valid === 1'b1)
            rsp_seen = rsp_seen + 1;
        if (req_reject === 1'b1)
            reject_seen = reject_seen + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare_byte(input string test, input logic [eeprom_bus_pkg::DATA_W-1:0] exp,
                                input logic [eeprom_bus_pkg::DATA_W-1:0] act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %h, actual %h", test, exp, act));
    endtask

    task automatic compare_chan(input string test, input logic [eeprom_sys_pkg::CHAN_W-1:0] exp,
                                input logic [eeprom_sys_pkg::CHAN_W-1:0] act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %0d, actual %0d", test, exp, act));
    endtask

    task automatic compare_flag(input string test, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %b, actual %b", test, exp, act));
    endtask

    // holds the strobe for one cycle, called at 1 unit after a rising edge
    task automatic drive_req(input logic wr, input logic rd,
                             input logic [eeprom_sys_pkg::CHAN_W-1:0] chan,
                             input logic [eeprom_bus_pkg::ADDR_W-1:0] addr,
                             input logic [eeprom_bus_pkg::DATA_W-1:0] wdata);
        req_wr    = wr;
        req_rd    = rd;
        req_chan  = chan;
        req_addr  = addr;
        req_wdata = wdata;
        @(posedge CLK);
        #1;
        req_wr = 1'b0;
        req_rd = 1'b0;
    endtask

    task automatic wait_rsp(input string test, output logic [eeprom_sys_pkg::CHAN_W-1:0] chan,
                            output logic nack, output logic [eeprom_bus_pkg::DATA_W-1:0] data);
        do
            @(negedge CLK);
        while (rsp_valid !== 1'b1);
        chan = rsp_chan;
        nack = rsp_nack;
        data = rsp_rdata;
        compare_flag({test, " busy held"}, 1'b1, busy[rsp_chan]);
    endtask

    task automatic transact(input string test, input logic rd,
                            input logic [eeprom_sys_pkg::CHAN_W-1:0] chan,
                            input logic [eeprom_bus_pkg::ADDR_W-1:0] addr,
                            input logic [eeprom_bus_pkg::DATA_W-1:0] data,
                            input logic exp_nack);
        logic [eeprom_sys_pkg::CHAN_W-1:0] got_chan;
        logic                              got_nack;
        logic [eeprom_bus_pkg::DATA_W-1:0] got_data;
        @(posedge CLK);
        #1;
        drive_req(!rd, rd, chan, addr, data);
        wait_rsp(test, got_chan, got_nack, got_data);
        compare_chan(test, chan, got_chan);
        compare_flag(test, exp_nack, got_nack);
        if (rd && !exp_nack)
            compare_byte(test, data, got_data);
        @(negedge CLK);
        compare_flag({test, " busy release"}, 1'b0, busy[chan]);
    endtask

    task automatic collect_parallel(input string test, input logic is_read);
        logic [eeprom_sys_pkg::CHAN_W-1:0]   got_chan;
        logic                                got_nack;
        logic [eeprom_bus_pkg::DATA_W-1:0]   got_data;
        logic [eeprom_sys_pkg::NUM_CHAN-1:0] seen;
        seen = '0;
        repeat (3)
        begin
            wait_rsp(test, got_chan, got_nack, got_data);
            if (got_chan > 2 || seen[got_chan])
                fail_run($sformatf("%s: unexpected or repeated result from channel %0d",
                                   test, got_chan));
            seen[got_chan] = 1'b1;
            compare_flag(test, 1'b0, got_nack);
            if (is_read)
                compare_byte(test, par_data[got_chan], got_data);
        end
        @(negedge CLK);
        for (int c = 0; c < 3; c++)
            compare_flag({test, " busy release"}, 1'b0, busy[c]);
    endtask

    task automatic test_reset_state();
        for (int c = 0; c < eeprom_sys_pkg::NUM_CHAN; c++)
            compare_flag("reset busy", 1'b0, busy[c]);
        repeat (20)
        begin
            @(negedge CLK);
            compare_flag("reset rsp_valid", 1'b0, rsp_valid);
            compare_flag("reset req_reject", 1'b0, req_reject);
            for (int c = 0; c < eeprom_sys_pkg::NUM_CHAN; c++)
            begin
                compare_flag("reset scl", 1'b1, scl[c]);
                compare_flag("reset sda", 1'b1, sda[c]);
            end
        end
    endtask

    task automatic test_write_read();
        logic [eeprom_bus_pkg::ADDR_W-1:0] addr;
        logic [eeprom_bus_pkg::DATA_W-1:0] data;
        addr = eeprom_bus_pkg::ADDR_W'($urandom);
        data = eeprom_bus_pkg::DATA_W'($urandom);
        transact("write_read write", 1'b0, 2'd0, addr, data, 1'b0);
        transact("write_read read", 1'b1, 2'd0, addr, data, 1'b0);
    endtask

    task automatic test_block_bits();
        logic [eeprom_bus_pkg::ADDR_W-1:0] a1;
        logic [eeprom_bus_pkg::ADDR_W-1:0] a2;
        logic [eeprom_bus_pkg::DATA_W-1:0] d1;
        a1 = eeprom_bus_pkg::ADDR_W'($urandom);
        a2 = a1 + eeprom_bus_pkg::ADDR_W'(256);     // next block, same low byte
        d1 = eeprom_bus_pkg::DATA_W'($urandom);
        transact("block write a", 1'b0, 2'd1, a1, d1, 1'b0);
        transact("block write b", 1'b0, 2'd1, a2, ~d1, 1'b0);
        transact("block read a", 1'b1, 2'd1, a1, d1, 1'b0);
        transact("block read b", 1'b1, 2'd1, a2, ~d1, 1'b0);
    endtask

    task automatic test_parallel();
        for (int c = 0; c < 3; c++)
        begin
            par_addr[c] = eeprom_bus_pkg::ADDR_W'($urandom);
            par_data[c] = eeprom_bus_pkg::DATA_W'($urandom);
        end
        @(posedge CLK);
        #1;
        for (int c = 0; c < 3; c++)
            drive_req(1'b1, 1'b0, 2'(c), par_addr[c], par_data[c]);
        collect_parallel("parallel write", 1'b0);
        @(posedge CLK);
        #1;
        for (int c = 0; c < 3; c++)
            drive_req(1'b0, 1'b1, 2'(c), par_addr[c], 8'h00);
        collect_parallel("parallel read", 1'b1);
    endtask

    task automatic test_reject();
        logic [eeprom_bus_pkg::ADDR_W-1:0] addr;
        logic [eeprom_bus_pkg::DATA_W-1:0] data;
        logic [eeprom_sys_pkg::CHAN_W-1:0] got_chan;
        logic                              got_nack;
        logic [eeprom_bus_pkg::DATA_W-1:0] got_data;
        int                                base_rsp;
        int                                base_rej;
        addr = eeprom_bus_pkg::ADDR_W'($urandom);
        data = eeprom_bus_pkg::DATA_W'($urandom);
        @(posedge CLK);
        #1;
        base_rsp = rsp_seen;
        base_rej = reject_seen;
        drive_req(1'b1, 1'b0, 2'd1, addr, data);
        @(posedge CLK);     // busy follows start by a cycle
        #1;
        drive_req(1'b1, 1'b0, 2'd1, addr, ~data);   // channel 1 now busy
        drive_req(1'b1, 1'b1, 2'd2, addr, data);    // both strobes
        wait_rsp("reject write", got_chan, got_nack, got_data);
        compare_chan("reject write", 2'd1, got_chan);
        compare_flag("reject write", 1'b0, got_nack);
        compare_flag("reject idle channel", 1'b0, busy[2]);
        repeat (250) @(posedge CLK);
        #1;
        if (rsp_seen - base_rsp != 1 || reject_seen - base_rej != 2)
            fail_run($sformatf("reject: expected one result and two rejects, saw %0d and %0d",
                               rsp_seen - base_rsp, reject_seen - base_rej));
        transact("reject read back", 1'b1, 2'd1, addr, data, 1'b0);
    endtask

    task automatic test_missing_ack();
        logic [eeprom_bus_pkg::ADDR_W-1:0] addr;
        logic [eeprom_bus_pkg::DATA_W-1:0] data;
        addr = eeprom_bus_pkg::ADDR_W'($urandom);
        data = eeprom_bus_pkg::DATA_W'($urandom);
        chan3_present = 1'b0;
        transact("absent write", 1'b0, 2'd3, addr, data, 1'b1);
        transact("absent read", 1'b1, 2'd3, addr, data, 1'b1);
        chan3_present = 1'b1;
        transact("present write", 1'b0, 2'd3, addr, data, 1'b0);
        transact("present read", 1'b1, 2'd3, addr, data, 1'b0);
    endtask

    initial
    begin
        CLK           = 1'b0;
        RESET         = 1'b1;
        req_wr        = 1'b0;
        req_rd        = 1'b0;
        req_chan      = '0;
        req_addr      = '0;
        req_wdata     = '0;
        chan3_present = 1'b1;
        cycles        = 0;
        rsp_seen      = 0;
        reject_seen   = 0;
        seed          = 32'hc4e39648;
        void'($urandom(seed));
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;
        test_reset_state();
        test_write_read();
        test_block_bits();
        test_parallel();
        test_reject();
        test_missing_ack();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/eeprom_model.sv ====
`default_nettype none

module eeprom_model (
    input  wire scl,
    inout  wire sda,
    input  wire present
);

    logic [7:0]  mem [0:2047];
    logic [7:0]  shift;
    logic [7:0]  out_byte;
    logic [10:0] ptr;
    int          bit_cnt;
    int          byte_no;       // bytes since the last start
    logic        listening;
    logic        sending;
    logic        send_next;
    logic        ack_due;
    logic        drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3));
        listening = 1'b0;
        sending   = 1'b0;
        send_next = 1'b0;
        ack_due   = 1'b0;
        drive_low = 1'b0;
        bit_cnt   = 0;
        byte_no   = 0;
        ptr       = '0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            listening = 1'b1;
            sending   = 1'b0;
            send_next = 1'b0;
            ack_due   = 1'b0;
            bit_cnt   = 0;
            byte_no   = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            listening = 1'b0;   // stop
            sending   = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (listening && bit_cnt < 8)
        begin
            shift   = {shift[6:0], sda};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8 && !sending)
            begin
                ack_due = 1'b1;
                if (byte_no == 0)
                begin
                    if (present === 1'b1 && shift[7:4] == 4'b1010)
                    begin
                        ptr[10:8] = shift[3:1];     // block bits
                        send_next = shift[0];
                        out_byte  = mem[ptr];
                    end
                    else
                    begin
                        ack_due   = 1'b0;
                        listening = 1'b0;   // not addressed
                    end
                end
                else if (byte_no == 1)
                    ptr[7:0] = shift;
                else if (byte_no == 2)
                    mem[ptr] = shift;
                else
                    ack_due = 1'b0;
                byte_no = byte_no + 1;
            end
        end
        else if (listening)
        begin
            // ninth clock, the acknowledge bit
            bit_cnt = 0;
            ack_due = 1'b0;
            if (sending)
                listening = 1'b0;   // single read byte only
            sending   = send_next;
            send_next = 1'b0;
        end
    end

    always @(negedge scl)
    begin
        if (listening && bit_cnt == 8 && ack_due)
            drive_low = 1'b1;
        else if (listening && sending && bit_cnt < 8)
            drive_low = !out_byte[7 - bit_cnt];
        else
            drive_low = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/eeprom_multi_ctrl.sv ====
`default_nettype none

module eeprom_multi_ctrl (
    input  logic                                CLK,
    input  logic                                RESET,
    input  logic                                req_wr,
    input  logic                                req_rd,
    input  logic [eeprom_sys_pkg::CHAN_W-1:0]   req_chan,
    input  logic [eeprom_bus_pkg::ADDR_W-1:0]   req_addr,
    input  logic [eeprom_bus_pkg::DATA_W-1:0]   req_wdata,
    output wire                                 req_reject,
    output wire                                 rsp_valid,
    output wire                                 rsp_nack,
    output wire  [eeprom_sys_pkg::CHAN_W-1:0]   rsp_chan,
    output wire  [eeprom_bus_pkg::DATA_W-1:0]   rsp_rdata,
    output wire  [eeprom_sys_pkg::NUM_CHAN-1:0] busy,
    output wire  [eeprom_sys_pkg::NUM_CHAN-1:0] scl,
    inout  wire  [eeprom_sys_pkg::NUM_CHAN-1:0] sda
);

    wire [eeprom_sys_pkg::NUM_CHAN-1:0]                             start;
    wire                                                            op_read;
    wire [eeprom_bus_pkg::ADDR_W-1:0]                               op_addr;
    wire [eeprom_bus_pkg::DATA_W-1:0]                               op_wdata;
    wire [eeprom_sys_pkg::NUM_CHAN-1:0]                             done;
    wire [eeprom_sys_pkg::NUM_CHAN-1:0]                             nack;
    wire [eeprom_sys_pkg::NUM_CHAN-1:0][eeprom_bus_pkg::DATA_W-1:0] rdata;
    wire [eeprom_sys_pkg::NUM_CHAN-1:0]                             release_result;
    wire [eeprom_sys_pkg::NUM_CHAN-1:0]                             sda_drive_low;

    eeprom_cmd_dispatch eeprom_cmd_dispatch_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_wr     (req_wr),
        .req_rd     (req_rd),
        .req_chan   (req_chan),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .busy       (busy),
        .req_reject (req_reject),
        .start      (start),
        .op_read    (op_read),
        .op_addr    (op_addr),
        .op_wdata   (op_wdata)
    );

    genvar g;
    generate
        for (g = 0; g < eeprom_sys_pkg::NUM_CHAN; g++)
        begin : gen_chan
            eeprom_bus_master eeprom_bus_master_i (
                .CLK            (CLK),
                .RESET          (RESET),
                .start          (start[g]),
                .op_read        (op_read),
                .op_addr        (op_addr),
                .op_wdata       (op_wdata),
                .sda_in         (sda[g]),
                .release_result (release_result[g]),
                .busy           (busy[g]),
                .done           (done[g]),
                .nack           (nack[g]),
                .rdata          (rdata[g]),
                .scl            (scl[g]),
                .sda_drive_low  (sda_drive_low[g])
            );

            assign sda[g] = sda_drive_low[g] ? 1'b0 : 1'bz;    // pull-up on the board
        end
    endgenerate

    eeprom_result_collect eeprom_result_collect_i (
        .CLK            (CLK),
        .RESET          (RESET),
        .done           (done),
        .nack           (nack),
        .rdata          (rdata),
        .release_result (release_result),
        .rsp_valid      (rsp_valid),
        .rsp_nack       (rsp_nack),
        .rsp_chan       (rsp_chan),
        .rsp_rdata      (rsp_rdata)
    );

endmodule

`default_nettype wire

// ==== verilog/eeprom_result_collect.sv ====
`default_nettype none

module eeprom_result_collect (
    input  logic                                                          CLK,
    input  logic                                                          RESET,
    input  logic [eeprom_sys_pkg::NUM_CHAN-1:0]                           done,
    input  logic [eeprom_sys_pkg::NUM_CHAN-1:0]                           nack,
    input  logic [eeprom_sys_pkg::NUM_CHAN-1:0][eeprom_bus_pkg::DATA_W-1:0] rdata,
    output logic [eeprom_sys_pkg::NUM_CHAN-1:0]                           release_result,
    output logic                                                          rsp_valid,
    output logic                                                          rsp_nack,
    output logic [eeprom_sys_pkg::CHAN_W-1:0]                             rsp_chan,
    output logic [eeprom_bus_pkg::DATA_W-1:0]                             rsp_rdata
);

    logic [eeprom_sys_pkg::NUM_CHAN-1:0]                            pend;
    logic [eeprom_sys_pkg::NUM_CHAN-1:0]                            avail;
    logic [eeprom_sys_pkg::NUM_CHAN-1:0]                            nack_q;
    logic [eeprom_sys_pkg::NUM_CHAN-1:0][eeprom_bus_pkg::DATA_W-1:0] rdata_q;
    logic [eeprom_sys_pkg::CHAN_W-1:0]                              last;
    logic [eeprom_sys_pkg::CHAN_W-1:0]                              cand;
    logic [eeprom_sys_pkg::CHAN_W-1:0]                              sel;
    logic                                                           found;

    assign avail = pend | done;     // fresh completions count this cycle

    // round robin, search starts after the last served channel
    always_comb
    begin
        found = 1'b0;
        sel   = last;
        cand  = last;
        for (int i = 1; i <= eeprom_sys_pkg::NUM_CHAN; i++)
        begin
            cand = eeprom_sys_pkg::CHAN_W'((int'(last) + i) % eeprom_sys_pkg::NUM_CHAN);
            if (!found && avail[cand])
            begin
                found = 1'b1;
                sel   = cand;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend           <= '0;
            last           <= eeprom_sys_pkg::CHAN_W'(eeprom_sys_pkg::NUM_CHAN - 1);
            rsp_valid      <= 1'b0;
            release_result <= '0;
        end
        else
        begin
            pend           <= avail & ~(found ? (eeprom_sys_pkg::NUM_CHAN'(1) << sel) : '0);
            rsp_valid      <= found;
            release_result <= found ? (eeprom_sys_pkg::NUM_CHAN'(1) << sel) : '0;
            if (found)
                last <= sel;
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < eeprom_sys_pkg::NUM_CHAN; i++)
        begin
            if (done[i])
            begin
                nack_q[i]  <= nack[i];
                rdata_q[i] <= rdata[i];
            end
        end
        if (found)
        begin
            rsp_chan  <= sel;
            rsp_nack  <= done[sel] ? nack[sel] : nack_q[sel];
            rsp_rdata <= done[sel] ? rdata[sel] : rdata_q[sel];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eeprom_bus_master.sv ====
`default_nettype none

module eeprom_bus_master (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              start,
    input  logic                              op_read,
    input  logic [eeprom_bus_pkg::ADDR_W-1:0] op_addr,
    input  logic [eeprom_bus_pkg::DATA_W-1:0] op_wdata,
    input  logic                              sda_in,
    input  logic                              release_result,
    output logic                              busy,
    output logic                              done,
    output logic                              nack,
    output logic [eeprom_bus_pkg::DATA_W-1:0] rdata,
    output logic                              scl,
    output logic                              sda_drive_low
);

    logic [eeprom_bus_pkg::ST_W-1:0]   state;
    logic [eeprom_bus_pkg::PH_W-1:0]   phase;
    logic [3:0]                        bit_cnt;   // 0..7 data, 8 ack
    logic [eeprom_bus_pkg::DATA_W-1:0] shreg;
    logic                              rd_q;
    logic [eeprom_bus_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_bus_pkg::DATA_W-1:0] wdata_q;
    eeprom_bus_pkg::ctrl_byte_t        ctrl;
    logic                              slot_end;
    logic                              ack_slot;
    logic                              rx_byte;
    logic                              cond_slot;

    assign busy      = (state != eeprom_bus_pkg::ST_IDLE);
    assign slot_end  = (phase == eeprom_bus_pkg::PH_W'(eeprom_bus_pkg::SCL_PERIOD - 1));
    assign ack_slot  = (bit_cnt == 4'd8);
    assign rx_byte   = (state == eeprom_bus_pkg::ST_DATA_R);
    assign cond_slot = (state == eeprom_bus_pkg::ST_START) ||
                       (state == eeprom_bus_pkg::ST_RSTART);

    always_comb
    begin
        ctrl.fields.dev   = eeprom_bus_pkg::DEVICE_CODE;
        ctrl.fields.block = addr_q[eeprom_bus_pkg::ADDR_W-1 -: eeprom_bus_pkg::BLOCK_W];
        ctrl.fields.rnw   = (state == eeprom_bus_pkg::ST_RSTART);
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= eeprom_bus_pkg::ST_IDLE;
            phase         <= '0;
            bit_cnt       <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            done          <= 1'b0;
            nack          <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == eeprom_bus_pkg::ST_IDLE)
            begin
                if (start)
                begin
                    state <= eeprom_bus_pkg::ST_START;
                    phase <= '0;
                    nack  <= 1'b0;
                end
            end
            else if (state == eeprom_bus_pkg::ST_DONE)
            begin
                if (release_result)
                    state <= eeprom_bus_pkg::ST_IDLE;
            end
            else
            begin
                phase <= slot_end ? '0 : phase + 1'b1;

                if (phase == eeprom_bus_pkg::PH_W'(eeprom_bus_pkg::SCL_HALF - 1))
                    scl <= 1'b1;
                else if (slot_end && state != eeprom_bus_pkg::ST_STOP)
                    scl <= 1'b0;    // scl stays high after stop

                // sda moves one clock into the low half, or mid high half for start/stop
                if (phase == '0)
                begin
                    if (cond_slot)
                        sda_drive_low <= 1'b0;
                    else if (state == eeprom_bus_pkg::ST_STOP)
                        sda_drive_low <= 1'b1;
                    else
                        sda_drive_low <= !ack_slot && !rx_byte && !shreg[eeprom_bus_pkg::DATA_W-1];
                end
                else if (phase == eeprom_bus_pkg::PH_W'(eeprom_bus_pkg::SCL_HALF))
                begin
                    if (cond_slot)
                        sda_drive_low <= 1'b1;          // start: sda falls, scl high
                    else if (state == eeprom_bus_pkg::ST_STOP)
                        sda_drive_low <= 1'b0;          // stop: sda rises, scl high
                end

                if (slot_end)
                begin
                    case (state)
                        eeprom_bus_pkg::ST_START:  state <= eeprom_bus_pkg::ST_CTRL_W;
                        eeprom_bus_pkg::ST_RSTART: state <= eeprom_bus_pkg::ST_CTRL_R;
                        eeprom_bus_pkg::ST_STOP:
                        begin
                            state <= eeprom_bus_pkg::ST_DONE;
                            done  <= 1'b1;
                        end
                        default:
                        begin
                            if (!ack_slot)
                                bit_cnt <= bit_cnt + 1'b1;
                            else
                            begin
                                bit_cnt <= '0;
                                if (rx_byte)
                                    state <= eeprom_bus_pkg::ST_STOP;
                                else if (sda_in)
                                begin
                                    nack  <= 1'b1;      // no slave ack, abort
                                    state <= eeprom_bus_pkg::ST_STOP;
                                end
                                else if (state == eeprom_bus_pkg::ST_CTRL_W)
                                    state <= eeprom_bus_pkg::ST_ADDR;
                                else if (state == eeprom_bus_pkg::ST_ADDR)
                                    state <= rd_q ? eeprom_bus_pkg::ST_RSTART
                                                  : eeprom_bus_pkg::ST_DATA_W;
                                else if (state == eeprom_bus_pkg::ST_CTRL_R)
                                    state <= eeprom_bus_pkg::ST_DATA_R;
                                else
                                    state <= eeprom_bus_pkg::ST_STOP;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && start)
        begin
            rd_q    <= op_read;
            addr_q  <= op_addr;
            wdata_q <= op_wdata;
        end
        if (slot_end)
        begin
            if (cond_slot)
                shreg <= ctrl.raw;
            else if (!ack_slot)
                shreg <= {shreg[eeprom_bus_pkg::DATA_W-2:0], sda_in};  // tx and rx share it
            else if (state == eeprom_bus_pkg::ST_CTRL_W)
                shreg <= addr_q[eeprom_bus_pkg::DATA_W-1:0];
            else if (state == eeprom_bus_pkg::ST_ADDR)
                shreg <= wdata_q;
            if (rx_byte && ack_slot)
                rdata <= shreg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eeprom_cmd_dispatch.sv ====
`default_nettype none

module eeprom_cmd_dispatch (
    input  logic                                CLK,
    input  logic                                RESET,
    input  logic                                req_wr,
    input  logic                                req_rd,
    input  logic [eeprom_sys_pkg::CHAN_W-1:0]   req_chan,
    input  logic [eeprom_bus_pkg::ADDR_W-1:0]   req_addr,
    input  logic [eeprom_bus_pkg::DATA_W-1:0]   req_wdata,
    input  logic [eeprom_sys_pkg::NUM_CHAN-1:0] busy,
    output logic                                req_reject,
    output logic [eeprom_sys_pkg::NUM_CHAN-1:0] start,
    output logic                                op_read,
    output logic [eeprom_bus_pkg::ADDR_W-1:0]   op_addr,
    output logic [eeprom_bus_pkg::DATA_W-1:0]   op_wdata
);

    logic any_req;
    logic chan_busy;
    logic accept;

    assign any_req   = req_wr | req_rd;
    assign chan_busy = busy[req_chan] | start[req_chan];   // busy lags start by a cycle
    assign accept    = any_req && !(req_wr && req_rd) && !chan_busy;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            req_reject <= 1'b0;
            start      <= '0;
        end
        else
        begin
            req_reject <= any_req && !accept;
            start      <= accept ? (eeprom_sys_pkg::NUM_CHAN'(1) << req_chan) : '0;
        end
    end

    // operation shared by all masters, only the started one latches it
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_read  <= req_rd;
            op_addr  <= req_addr;
            op_wdata <= req_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eeprom_sys_pkg.sv ====
`default_nettype none

package eeprom_sys_pkg;

    localparam int NUM_CHAN = 4;    // one eeprom per bus
    localparam int CHAN_W   = 2;

endpackage

`default_nettype wire

// ==== verilog/eeprom_bus_pkg.sv ====
`default_nettype none

package eeprom_bus_pkg;

    localparam int DATA_W  = 8;
    localparam int ADDR_W  = 11;
    localparam int BLOCK_W = 3;             // address bits carried in the control byte

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int SCL_HALF   = 2;          // clocks per scl level
    localparam int SCL_PERIOD = 2 * SCL_HALF;
    localparam int PH_W       = $clog2(SCL_PERIOD);

    // sequencer states of the bus master
    localparam int ST_W = 4;
    localparam logic [ST_W-1:0] ST_IDLE   = 4'd0;
    localparam logic [ST_W-1:0] ST_START  = 4'd1;
    localparam logic [ST_W-1:0] ST_CTRL_W = 4'd2;
    localparam logic [ST_W-1:0] ST_ADDR   = 4'd3;
    localparam logic [ST_W-1:0] ST_DATA_W = 4'd4;
    localparam logic [ST_W-1:0] ST_RSTART = 4'd5;
    localparam logic [ST_W-1:0] ST_CTRL_R = 4'd6;
    localparam logic [ST_W-1:0] ST_DATA_R = 4'd7;
    localparam logic [ST_W-1:0] ST_STOP   = 4'd8;
    localparam logic [ST_W-1:0] ST_DONE   = 4'd9;

    typedef union packed {
        logic [DATA_W-1:0] raw;             // msb goes out first
        struct packed {
            logic [3:0]         dev;
            logic [BLOCK_W-1:0] block;
            logic               rnw;        // 1 = read
        } fields;
    } ctrl_byte_t;

endpackage

`default_nettype wire
